// File: pmp_csr_regs.sv
`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_csr_regs (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic                                          csr_req_i,
  input  logic                                          csr_we_i,
  input  logic [`PMP_CSR_ADDR_W-1:0]                    csr_addr_i,
  input  logic [`PMP_CSR_DATA_W-1:0]                    csr_wdata_i,
  output logic                                          csr_ack_o,
  output logic [`PMP_CSR_DATA_W-1:0]                    csr_rdata_o,
  output logic [`PMP_NUM_REGIONS-1:0][7:0]              cfg_o,
  output logic [`PMP_NUM_REGIONS-1:0][`PMP_AWORD_W-1:0] addr_o
);
  import pmp_pkg::*;

  typedef enum logic {
    IDLE,
    ACKED
  } csr_state_e;

  csr_state_e                                  state_q;
  logic [`PMP_NUM_REGIONS-1:0][7:0]            cfg_q;
  logic [`PMP_NUM_REGIONS-1:0][7:0]            cfg_d;
  logic [`PMP_NUM_REGIONS-1:0][`PMP_AWORD_W-1:0] addr_q;
  logic [`PMP_NUM_REGIONS-1:0][`PMP_AWORD_W-1:0] addr_d;
  logic                                        rlb_q;
  logic                                        rlb_d;
  logic [`PMP_NUM_REGIONS-1:0]                 entry_locked;  // L set and no bypass
  logic [`PMP_NUM_REGIONS-1:0]                 addr_protected;
  logic                                        any_l;
  logic                                        wr_en;
  logic [`PMP_CSR_DATA_W-1:0]                  rdata_d;

  // Reserved W-without-R encoding falls back to the old permissions
  function automatic logic [7:0] rectify_cfg(input logic [7:0] old_cfg,
                                             input logic [7:0] new_cfg);
    logic [7:0] res;
    res = new_cfg;
    if (!new_cfg[PMP_CFG_R] && new_cfg[PMP_CFG_W]) begin
      res[PMP_CFG_X:PMP_CFG_R] = old_cfg[PMP_CFG_X:PMP_CFG_R];
    end
    res[PMP_CFG_ZERO_HI:PMP_CFG_ZERO_LO] = 2'b00;
    return res;
  endfunction

  assign wr_en = csr_req_i && csr_we_i && (state_q == IDLE);  // One write per handshake

  always_comb begin
    any_l = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      entry_locked[i]   = cfg_q[i][PMP_CFG_L] && !rlb_q;
      addr_protected[i] = entry_locked[i];
      any_l             = any_l | cfg_q[i][PMP_CFG_L];
    end
    // A locked TOR entry also guards the word below it
    for (int i = 0; i < `PMP_NUM_REGIONS - 1; i++) begin
      if (entry_locked[i+1] && (cfg_q[i+1][PMP_CFG_A_HI:PMP_CFG_A_LO] == TOR)) begin
        addr_protected[i] = 1'b1;
      end
    end
  end

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    rlb_d  = rlb_q;
    if (wr_en) begin
      for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
        if ((csr_addr_i == `PMP_CSR_ADDR_W'(`PMP_CSR_PMPCFG0 + i / 4)) && !entry_locked[i]) begin
          cfg_d[i] = rectify_cfg(cfg_q[i], csr_wdata_i[8*(i%4) +: 8]);
        end
        if ((csr_addr_i == `PMP_CSR_ADDR_W'(`PMP_CSR_PMPADDR0 + i)) && !addr_protected[i]) begin
          addr_d[i] = csr_wdata_i[`PMP_AWORD_W-1:0];
        end
      end
      // RLB may only be raised before anything is locked
      if ((csr_addr_i == `PMP_CSR_MSECCFG) && (rlb_q || !any_l)) begin
        rlb_d = csr_wdata_i[PMP_MSECCFG_RLB];
      end
    end
  end

  // Read data shows the state after this access
  always_comb begin
    rdata_d = '0;
    for (int j = 0; j < `PMP_CFG_REGS; j++) begin
      if (csr_addr_i == `PMP_CSR_ADDR_W'(`PMP_CSR_PMPCFG0 + j)) begin
        rdata_d = cfg_d[4*j +: 4];
      end
    end
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (csr_addr_i == `PMP_CSR_ADDR_W'(`PMP_CSR_PMPADDR0 + i)) begin
        rdata_d = `PMP_CSR_DATA_W'(addr_d[i]);  // Upper two bits zero
      end
    end
    if (csr_addr_i == `PMP_CSR_MSECCFG) begin
      rdata_d[PMP_MSECCFG_RLB] = rlb_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cfg_q   <= '0;
      addr_q  <= '0;
      rlb_q   <= 1'b0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
      rlb_q  <= rlb_d;
      case (state_q)
        IDLE: begin
          if (csr_req_i) begin
            state_q <= ACKED;
          end
        end
        ACKED: begin
          if (!csr_req_i) begin  // Requester has let go
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && csr_req_i) begin
      csr_rdata_o <= rdata_d;
    end
  end

  assign csr_ack_o = (state_q == ACKED);
  assign cfg_o     = cfg_q;
  assign addr_o    = addr_q;

  // Locked entries hold both cfg and address until reset
  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : g_lock_chk
    a_locked_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      cfg_q[i][PMP_CFG_L] && !rlb_q |=> $stable(cfg_q[i]) && $stable(addr_q[i]));
  end

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(csr_ack_o) |-> $past(csr_req_i));

endmodule

// File: pmp_defines.svh
`ifndef PMP_DEFINES_SVH
`define PMP_DEFINES_SVH

// Region count, fixed by the two pmpcfg registers of the CSR map
`define PMP_NUM_REGIONS 8
`define PMP_CFG_REGS    (`PMP_NUM_REGIONS / 4)  // Four cfg bytes per pmpcfg

// Physical address and the word view held in pmpaddr
`define PMP_ADDR_W      32
`define PMP_AWORD_W     (`PMP_ADDR_W - 2)       // pmpaddr holds bits 31:2

// CSR port widths
`define PMP_CSR_ADDR_W  12
`define PMP_CSR_DATA_W  32

// CSR numbers
`define PMP_CSR_PMPCFG0  12'h3A0
`define PMP_CSR_PMPADDR0 12'h3B0
`define PMP_CSR_MSECCFG  12'h747

`endif

// File: pmp_pkg.sv
package pmp_pkg;

  // Address matching mode, cfg bits 4:3
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pmp_mode_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    EXEC  = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } pmp_access_e;

  // Privilege, same encoding as the RISC-V mode field
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } pmp_priv_e;

  // Bit positions inside one cfg byte
  localparam int PMP_CFG_R       = 0;
  localparam int PMP_CFG_W       = 1;
  localparam int PMP_CFG_X       = 2;
  localparam int PMP_CFG_A_LO    = 3;
  localparam int PMP_CFG_A_HI    = 4;
  localparam int PMP_CFG_ZERO_LO = 5;  // Bits 6:5 always read zero
  localparam int PMP_CFG_ZERO_HI = 6;
  localparam int PMP_CFG_L       = 7;

  // Rule locking bypass in mseccfg
  localparam int PMP_MSECCFG_RLB = 2;

endpackage

// File: pmp_priority_resolve.sv
`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_priority_resolve (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        chk_req_i,
  input  logic [`PMP_ADDR_W-1:0]      chk_addr_i,
  input  pmp_pkg::pmp_access_e        chk_kind_i,
  input  pmp_pkg::pmp_priv_e          chk_priv_i,
  input  logic [`PMP_NUM_REGIONS-1:0] region_match_i,
  input  logic [`PMP_NUM_REGIONS-1:0] region_perm_ok_i,
  input  logic [`PMP_NUM_REGIONS-1:0] region_locked_i,
  output logic [`PMP_ADDR_W-1:0]      cap_addr_o,
  output pmp_pkg::pmp_access_e        cap_kind_o,
  output logic                        chk_ack_o,
  output logic                        chk_allow_o
);
  import pmp_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    EVAL,
    ACKED
  } chk_state_e;

  chk_state_e state_q;
  pmp_priv_e  cap_priv_q;
  logic       hit;
  logic       hit_perm;
  logic       hit_lock;
  logic       allow_d;
  logic       allow_q;

  // Walk downwards so the lowest matching region wins
  always_comb begin
    hit      = 1'b0;
    hit_perm = 1'b0;
    hit_lock = 1'b0;
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_match_i[i]) begin
        hit      = 1'b1;
        hit_perm = region_perm_ok_i[i];
        hit_lock = region_locked_i[i];
      end
    end
  end

  always_comb begin
    if (!hit) begin
      allow_d = (cap_priv_q == PRIV_M);  // Default open for M, closed for U
    end else if (cap_priv_q == PRIV_M) begin
      allow_d = !hit_lock || hit_perm;   // Unlocked regions do not bind M
    end else begin
      allow_d = hit_perm;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      allow_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (chk_req_i) begin
            state_q <= EVAL;
          end
        end
        EVAL: begin
          state_q <= ACKED;
          allow_q <= allow_d;  // Matchers now see the captured address
        end
        ACKED: begin
          if (!chk_req_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request capture
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && chk_req_i) begin
      cap_addr_o <= chk_addr_i;
      cap_kind_o <= chk_kind_i;
      cap_priv_q <= chk_priv_i;
    end
  end

  assign chk_ack_o   = (state_q == ACKED);
  assign chk_allow_o = allow_q;

  a_ack_holds_for_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(chk_ack_o) |-> $past(!chk_req_i));

endmodule

// File: pmp_region_match.sv
`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_region_match (
  input  logic [7:0]              cfg_i,
  input  logic [`PMP_AWORD_W-1:0] addr_i,
  input  logic [`PMP_AWORD_W-1:0] addr_below_i,  // Lower TOR bound
  input  logic [`PMP_ADDR_W-1:0]  chk_addr_i,
  input  pmp_pkg::pmp_access_e    chk_kind_i,
  output logic                    match_o,
  output logic                    perm_ok_o
);
  import pmp_pkg::*;

  pmp_mode_e               mode;
  logic [`PMP_AWORD_W-1:0] chk_word;
  logic [`PMP_AWORD_W-1:0] addr_inc;
  logic [`PMP_AWORD_W-1:0] napot_mask;
  logic                    tor_hit;
  logic                    na4_hit;
  logic                    napot_hit;

  assign mode     = pmp_mode_e'(cfg_i[PMP_CFG_A_HI:PMP_CFG_A_LO]);
  assign chk_word = chk_addr_i[`PMP_ADDR_W-1:2];  // Byte offset never matters

  // Word compares are enough since both bounds are word aligned
  assign tor_hit = (chk_word >= addr_below_i) && (chk_word < addr_i);
  assign na4_hit = (chk_word == addr_i);

  // Trailing ones plus the zero above them are don't-care bits
  assign addr_inc   = addr_i + `PMP_AWORD_W'(1);
  assign napot_mask = ~(addr_i ^ addr_inc);
  assign napot_hit  = ((chk_word ^ addr_i) & napot_mask) == '0;

  always_comb begin
    case (mode)
      TOR:     match_o = tor_hit;
      NA4:     match_o = na4_hit;
      NAPOT:   match_o = napot_hit;
      default: match_o = 1'b0;  // OFF
    endcase
  end

  always_comb begin
    case (chk_kind_i)
      EXEC:    perm_ok_o = cfg_i[PMP_CFG_X];
      READ:    perm_ok_o = cfg_i[PMP_CFG_R];
      WRITE:   perm_ok_o = cfg_i[PMP_CFG_W];
      default: perm_ok_o = 1'b0;
    endcase
  end

endmodule

// File: pmp_top.sv
`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_top (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // CSR port
  input  logic                       csr_req_i,
  input  logic                       csr_we_i,
  input  logic [`PMP_CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`PMP_CSR_DATA_W-1:0] csr_wdata_i,
  output logic                       csr_ack_o,
  output logic [`PMP_CSR_DATA_W-1:0] csr_rdata_o,

  // Check port
  input  logic                       chk_req_i,
  input  logic [`PMP_ADDR_W-1:0]     chk_addr_i,
  input  pmp_pkg::pmp_access_e       chk_kind_i,
  input  pmp_pkg::pmp_priv_e         chk_priv_i,
  output logic                       chk_ack_o,
  output logic                       chk_allow_o
);
  import pmp_pkg::*;

  logic [`PMP_NUM_REGIONS-1:0][7:0]              cfg;
  logic [`PMP_NUM_REGIONS-1:0][`PMP_AWORD_W-1:0] addr;
  logic [`PMP_NUM_REGIONS-1:0]                   region_match;
  logic [`PMP_NUM_REGIONS-1:0]                   region_perm_ok;
  logic [`PMP_NUM_REGIONS-1:0]                   region_locked;
  logic [`PMP_ADDR_W-1:0]                        cap_addr;
  pmp_access_e                                   cap_kind;

  pmp_csr_regs u_csr_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .csr_req_i   (csr_req_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_ack_o   (csr_ack_o),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg),
    .addr_o      (addr)
  );

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : g_region
    logic [`PMP_AWORD_W-1:0] addr_below;

    if (i == 0) begin : g_first
      assign addr_below = '0;  // TOR in region 0 starts at address zero
    end else begin : g_next
      assign addr_below = addr[i-1];
    end

    assign region_locked[i] = cfg[i][PMP_CFG_L];  // Raw L bit, RLB only affects writes

    pmp_region_match u_match (
      .cfg_i        (cfg[i]),
      .addr_i       (addr[i]),
      .addr_below_i (addr_below),
      .chk_addr_i   (cap_addr),
      .chk_kind_i   (cap_kind),
      .match_o      (region_match[i]),
      .perm_ok_o    (region_perm_ok[i])
    );
  end

  pmp_priority_resolve u_resolve (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .chk_req_i        (chk_req_i),
    .chk_addr_i       (chk_addr_i),
    .chk_kind_i       (chk_kind_i),
    .chk_priv_i       (chk_priv_i),
    .region_match_i   (region_match),
    .region_perm_ok_i (region_perm_ok),
    .region_locked_i  (region_locked),
    .cap_addr_o       (cap_addr),
    .cap_kind_o       (cap_kind),
    .chk_ack_o        (chk_ack_o),
    .chk_allow_o      (chk_allow_o)
  );

endmodule

// File: project.f
+incdir+.
pmp_pkg.sv
pmp_csr_regs.sv
pmp_region_match.sv
pmp_priority_resolve.sv
pmp_top.sv
tb_pmp.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PMP testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_pmp -o tb_pmp_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_pmp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG" || ! grep -q "TEST OK" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: tb_pmp.sv
`timescale 1ns/1ps

`include "pmp_defines.svh"

module tb_pmp;
  import pmp_pkg::*;

  localparam int CYCLE_LIMIT = 4000;  // Tests need about 2000 cycles

  logic                       clk_i;
  logic                       rst_i;
  logic                       csr_req_i;
  logic                       csr_we_i;
  logic [`PMP_CSR_ADDR_W-1:0] csr_addr_i;
  logic [`PMP_CSR_DATA_W-1:0] csr_wdata_i;
  logic                       csr_ack_o;
  logic [`PMP_CSR_DATA_W-1:0] csr_rdata_o;
  logic                       chk_req_i;
  logic [`PMP_ADDR_W-1:0]     chk_addr_i;
  pmp_access_e                chk_kind_i;
  pmp_priv_e                  chk_priv_i;
  logic                       chk_ack_o;
  logic                       chk_allow_o;

  // Shadow copy of the register bank
  logic [7:0]  cfg_m [`PMP_NUM_REGIONS];
  logic [29:0] addr_m [`PMP_NUM_REGIONS];
  logic        rlb_m;

  logic        exp_allow = 1'b0;
  logic        chk_ack_seen = 1'b0;
  int          seed = 32'hc3f3d7d1;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          cycle_cnt = 0;
  logic [11:0] reg_map [13] = '{12'h3A0, 12'h3A1, 12'h3B0, 12'h3B1, 12'h3B2, 12'h3B3, 12'h3B4,
                                12'h3B5, 12'h3B6, 12'h3B7, 12'h747, 12'h3A2, 12'h3C0};
  logic [31:0] bound_addr [12] = '{32'h1FFC, 32'h2000, 32'h2FFC, 32'h3000, 32'h3FFC, 32'h4000,
                                   32'h4003, 32'h4004, 32'h7FFC, 32'h8000, 32'h80FF, 32'h8100};
  logic [31:0] prio_addr [5] = '{32'h8010, 32'h8200, 32'h9000, 32'hF000, 32'h2004};

  pmp_top dut0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .csr_req_i   (csr_req_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_ack_o   (csr_ack_o),
    .csr_rdata_o (csr_rdata_o),
    .chk_req_i   (chk_req_i),
    .chk_addr_i  (chk_addr_i),
    .chk_kind_i  (chk_kind_i),
    .chk_priv_i  (chk_priv_i),
    .chk_ack_o   (chk_ack_o),
    .chk_allow_o (chk_allow_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, want);
    end
  endtask

  // Allow decision is checked once per access, when ack first shows up
  always @(negedge clk_i) begin
    if (chk_ack_o && !chk_ack_seen) begin
      compare("chk_allow_o", 32'(chk_allow_o), 32'(exp_allow));
    end
    chk_ack_seen = chk_ack_o;
  end

  function automatic logic entry_locked(input int i);
    return cfg_m[i][PMP_CFG_L] && !rlb_m;
  endfunction

  function automatic void model_write(input logic [11:0] a, input logic [31:0] d);
    logic [7:0] b;
    logic       any_l;
    any_l = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      any_l = any_l | cfg_m[i][PMP_CFG_L];
    end
    if ((a == `PMP_CSR_MSECCFG) && (rlb_m || !any_l)) begin
      rlb_m = d[PMP_MSECCFG_RLB];
    end
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if ((a == `PMP_CSR_PMPCFG0 + 12'(i / 4)) && !entry_locked(i)) begin
        b = d[8*(i%4) +: 8];
        if (!b[PMP_CFG_R] && b[PMP_CFG_W]) begin
          b[2:0] = cfg_m[i][2:0];  // Reserved encoding keeps old RWX
        end
        b[6:5] = 2'b00;
        cfg_m[i] = b;
      end
      if ((a == `PMP_CSR_PMPADDR0 + 12'(i)) && !entry_locked(i) &&
          !((i < 7) && entry_locked(i + 1) && (cfg_m[i + 1][4:3] == 2'b01))) begin
        addr_m[i] = d[29:0];
      end
    end
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] a);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (a == `PMP_CSR_PMPCFG0 + 12'(i / 4)) begin
        v[8*(i%4) +: 8] = cfg_m[i];
      end
      if (a == `PMP_CSR_PMPADDR0 + 12'(i)) begin
        v = {2'b00, addr_m[i]};
      end
    end
    if (a == `PMP_CSR_MSECCFG) begin
      v[PMP_MSECCFG_RLB] = rlb_m;
    end
    return v;
  endfunction

  // Expected allow from the shadow registers, byte addresses in 64 bits
  function automatic logic ref_allow(input logic [31:0] a, input pmp_access_e kind,
                                     input pmp_priv_e priv);
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] size;
    logic        hit;
    logic        perm;
    int          k;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      hi = {32'd0, addr_m[i], 2'b00};
      if (i == 0) begin
        lo = 64'd0;
      end else begin
        lo = {32'd0, addr_m[i - 1], 2'b00};
      end
      case (pmp_mode_e'(cfg_m[i][4:3]))
        TOR:   hit = (lo <= {32'd0, a}) && ({32'd0, a} < hi);
        NA4:   hit = (a[31:2] == addr_m[i]);
        NAPOT: begin
          k = 0;
          while ((k < 30) && addr_m[i][k]) begin
            k++;
          end
          size = 64'd1 << (k + 3);  // k trailing ones
          hit  = (({32'd0, a} ^ hi) & ~(size - 64'd1)) == 64'd0;
        end
        default: hit = 1'b0;
      endcase
      case (kind)
        EXEC:    perm = cfg_m[i][PMP_CFG_X];
        READ:    perm = cfg_m[i][PMP_CFG_R];
        default: perm = cfg_m[i][PMP_CFG_W];
      endcase
      if (hit) begin
        return (priv == PRIV_M) ? (!cfg_m[i][PMP_CFG_L] || perm) : perm;
      end
    end
    return priv == PRIV_M;
  endfunction

  // Called on a falling edge, returns on a falling edge with ack low
  task automatic csr_xfer(input logic we, input logic [11:0] a, input logic [31:0] d,
                          input int hold, output logic [31:0] rdata);
    int edges;
    csr_req_i   = 1'b1;
    csr_we_i    = we;
    csr_addr_i  = a;
    csr_wdata_i = d;
    edges       = 0;
    do begin
      @(negedge clk_i);
      edges++;
    end while (!csr_ack_o);
    compare("csr_ack_o latency", edges, 1);
    rdata = csr_rdata_o;
    repeat (hold) begin
      @(negedge clk_i);
      compare("csr_ack_o", 32'(csr_ack_o), 32'd1);
    end
    csr_req_i = 1'b0;
    do begin
      @(negedge clk_i);
    end while (csr_ack_o);
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [31:0] d);
    logic [31:0] rdata;
    model_write(a, d);
    csr_xfer(1'b1, a, d, 0, rdata);
    compare("csr_rdata_o", rdata, model_read(a));
  endtask

  task automatic csr_read(input logic [11:0] a);
    logic [31:0] rdata;
    csr_xfer(1'b0, a, 32'd0, 0, rdata);
    compare("csr_rdata_o", rdata, model_read(a));
  endtask

  task automatic check_access(input logic [31:0] a, input pmp_access_e kind,
                              input pmp_priv_e priv, input int hold);
    int edges;
    exp_allow  = ref_allow(a, kind, priv);
    chk_req_i  = 1'b1;
    chk_addr_i = a;
    chk_kind_i = kind;
    chk_priv_i = priv;
    edges      = 0;
    do begin
      @(negedge clk_i);
      edges++;
    end while (!chk_ack_o);
    compare("chk_ack_o latency", edges, 2);
    repeat (hold) begin
      @(negedge clk_i);
      compare("chk_ack_o", 32'(chk_ack_o), 32'd1);
    end
    chk_req_i = 1'b0;
    do begin
      @(negedge clk_i);
    end while (chk_ack_o);
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    rlb_m = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      cfg_m[i]  = '0;
      addr_m[i] = '0;
    end
    compare("csr_ack_o", 32'(csr_ack_o), 32'd0);
    compare("chk_ack_o", 32'(chk_ack_o), 32'd0);
  endtask

  // Bounds in a small window so random checks hit regions often
  task automatic random_config();
    logic [31:0] w;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      csr_write(`PMP_CSR_PMPADDR0 + 12'(i), 32'h4000 + ($random(seed) & 32'h7ff));
    end
    for (int r = 0; r < 2; r++) begin
      w = $random(seed);
      for (int b = 0; b < 4; b++) begin
        if (w[8*b+1] && !w[8*b]) begin
          w[8*b] = 1'b1;
        end
      end
      csr_write(`PMP_CSR_PMPCFG0 + 12'(r), w);
    end
  endtask

  initial begin
    logic [31:0] rdata;
    csr_req_i   = 1'b0;
    csr_we_i    = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    chk_req_i   = 1'b0;
    chk_addr_i  = '0;
    chk_kind_i  = READ;
    chk_priv_i  = PRIV_U;
    rst_i       = 1'b1;
    apply_reset();
    csr_read(`PMP_CSR_PMPCFG0);
    csr_read(`PMP_CSR_PMPADDR0 + 12'd5);
    csr_read(`PMP_CSR_MSECCFG);

    // Read-back and rectification, L bits kept clear
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_0007);
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_0062);  // W without R plus bits 6:5
    for (int n = 0; n < 30; n++) begin
      csr_write(reg_map[($random(seed) & 32'h7fffffff) % 13], $random(seed) & 32'h7f7f7f7f);
    end
    foreach (reg_map[n]) begin
      csr_read(reg_map[n]);
    end

    // Locking with RLB clear
    apply_reset();
    csr_write(`PMP_CSR_PMPADDR0, 32'h0000_0400);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd1, 32'h0000_0800);
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_8900);   // Entry 1 locked TOR
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_0F07);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd1, 32'h0000_1234);
    csr_write(`PMP_CSR_PMPADDR0, 32'h0000_1234);  // Below the locked TOR
    csr_write(`PMP_CSR_PMPADDR0 + 12'd2, 32'h0000_1234);
    csr_write(`PMP_CSR_MSECCFG, 32'h0000_0004);   // Refused
    // RLB set first, then locks no longer bind writes
    apply_reset();
    csr_write(`PMP_CSR_MSECCFG, 32'h0000_0004);
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_8900);
    csr_write(`PMP_CSR_PMPCFG0, 32'h0000_0000);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd1, 32'h0000_0555);

    // TOR 0x2000..0x3000 RW, NA4 0x4000 X, NAPOT 0x8000/256 RX
    csr_write(`PMP_CSR_PMPADDR0, 32'h0000_0800);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd1, 32'h0000_0C00);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd2, 32'h0000_1000);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd3, 32'h0000_201F);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd4, 32'h0000_21FF);
    csr_write(`PMP_CSR_PMPADDR0 + 12'd5, 32'h0000_2400);
    csr_write(`PMP_CSR_PMPCFG0, 32'h1D14_0B00);
    foreach (bound_addr[n]) begin
      for (int k = 0; k < 3; k++) begin
        check_access(bound_addr[n], pmp_access_e'(2'(k)), PRIV_U, 0);
      end
    end

    // Locked NAPOT 0x8000/4K RWX behind region 3, locked NA4 0x9000 with no rights
    csr_write(`PMP_CSR_PMPCFG0 + 12'd1, 32'h0000_909F);
    foreach (prio_addr[n]) begin
      for (int k = 0; k < 3; k++) begin
        check_access(prio_addr[n], pmp_access_e'(2'(k)), PRIV_U, 0);
        check_access(prio_addr[n], pmp_access_e'(2'(k)), PRIV_M, 0);
      end
    end

    // Acks held while req stays high
    check_access(32'h0000_2004, READ, PRIV_U, 4);
    csr_xfer(1'b0, `PMP_CSR_PMPCFG0, 32'd0, 4, rdata);
    compare("csr_rdata_o", rdata, model_read(`PMP_CSR_PMPCFG0));

    for (int c = 0; c < 20; c++) begin
      random_config();
      for (int n = 0; n < 15; n++) begin
        check_access(32'h0001_0000 + ($random(seed) & 32'h1fff),
                     pmp_access_e'(2'(($random(seed) & 32'h7fffffff) % 3)),
                     ($random(seed) & 1) ? PRIV_M : PRIV_U, 0);
      end
    end

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
